// File: source/iob_pkg.sv
// Assumes a 22-bit word-addressed bus with a single 64-word I/O block at a fixed octal base

package iob_pkg;

   //////////////////////////////////////////////////
   // Widths

   typedef logic [21:0] addr_t;      // Bus word address
   typedef logic [31:0] word_t;      // Bus data word
   typedef logic [11:0] coord_t;     // Mouse coordinate
   typedef logic [31:0] key_scan_t;  // Tagged keyboard scan
   typedef logic [5:0]  reg_off_t;   // Offset inside the block

   //////////////////////////////////////////////////
   // Bus and sample bundles

   typedef struct packed {
      addr_t addr;
      word_t data;
      logic  write;                  // High for a write cycle
   } bus_req_t;

   typedef struct packed {
      logic [2:0] buttons;           // Head, middle, tail
      coord_t     x;
      coord_t     y;
   } mouse_t;

   //////////////////////////////////////////////////
   // Address map

   localparam addr_t iob_base = 22'o17772000;

   localparam reg_off_t reg_kbd_lo  = 6'o40;
   localparam reg_off_t reg_kbd_hi  = 6'o41;
   localparam reg_off_t reg_mouse_y = 6'o42;
   localparam reg_off_t reg_mouse_x = 6'o43;
   localparam reg_off_t reg_beep    = 6'o44;  // Reads zero, writes dropped
   localparam reg_off_t reg_csr     = 6'o45;
   localparam reg_off_t reg_us_lo   = 6'o50;
   localparam reg_off_t reg_us_hi   = 6'o51;
   localparam reg_off_t reg_hz60    = 6'o52;  // Read also starts 60 Hz count

   // Upper half of every key scan, eight zeros then 11111 then 001
   localparam logic [15:0] kbd_tag = 16'h00f9;

   //////////////////////////////////////////////////
   // Interrupt vectors

   localparam logic [7:0] vec_input = 8'o260;  // Keyboard or mouse
   localparam logic [7:0] vec_clock = 8'o274;  // 60 Hz tick

endpackage

// File: source/iob_timebase.sv
// Both dividers must be at least 1; the 60 Hz count holds at zero until the first start pulse

`timescale 1ns/1ps

module iob_timebase #(
   parameter int unsigned us_div   = 50,      // Clock cycles per microsecond
   parameter int unsigned hz60_div = 833333   // Clock cycles per 60 Hz tick
) (
   input  logic           clk,
   input  logic           reset,
   input  logic           hz60_start,
   output iob_pkg::word_t us_time,
   output iob_pkg::word_t hz60_time,
   output logic           hz60_tick
);

   localparam int unsigned us_w   = (us_div > 1) ? $clog2(us_div) : 1;
   localparam int unsigned hz60_w = (hz60_div > 1) ? $clog2(hz60_div) : 1;

   localparam logic [us_w-1:0]   us_last   = us_w'(us_div - 1);
   localparam logic [hz60_w-1:0] hz60_last = hz60_w'(hz60_div - 1);

   logic [us_w-1:0]   us_pre;    // Microsecond prescaler
   logic [hz60_w-1:0] hz60_pre;  // 60 Hz prescaler
   logic              hz60_en;   // Set by first start, held till reset
   logic              hz60_wrap;

   //////////////////////////////////////////////////
   // Microsecond clock, free running from reset

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         us_pre  <= '0;
         us_time <= '0;
      end
      else if (us_pre == us_last)
      begin
         us_pre  <= '0;
         us_time <= us_time + 1'b1;
      end
      else
      begin
         us_pre <= us_pre + 1'b1;
      end
   end

   //////////////////////////////////////////////////
   // 60 Hz tick counter, started on demand

   assign hz60_wrap = hz60_en && (hz60_pre == hz60_last);

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         hz60_en   <= 1'b0;
         hz60_pre  <= '0;
         hz60_time <= '0;
         hz60_tick <= 1'b0;
      end
      else
      begin
         if (hz60_start)
            hz60_en <= 1'b1;
         hz60_tick <= hz60_wrap;                 // Aligned with the increment
         if (hz60_wrap)
         begin
            hz60_pre  <= '0;
            hz60_time <= hz60_time + 1'b1;
         end
         else if (hz60_en)
         begin
            hz60_pre <= hz60_pre + 1'b1;
         end
      end
   end

endmodule

// File: source/iob_input_latch.sv
// Holds only the newest keyboard and mouse sample; a new strobe overwrites an unread one

`timescale 1ns/1ps

module iob_input_latch (
   input  logic               clk,
   input  logic               reset,
   input  logic [15:0]        kb_data,
   input  logic               kb_ready,
   input  iob_pkg::coord_t    ms_x,
   input  iob_pkg::coord_t    ms_y,
   input  logic [2:0]         ms_button,
   input  logic               ms_ready,
   output iob_pkg::key_scan_t key_scan,
   output iob_pkg::mouse_t    mouse,
   output logic               kb_event,
   output logic               ms_event
);

   import iob_pkg::*;

   //////////////////////////////////////////////////
   // Keyboard

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         key_scan <= '0;
         kb_event <= 1'b0;
      end
      else
      begin
         kb_event <= kb_ready;                   // Lines up with new scan
         if (kb_ready)
            key_scan <= {kbd_tag, kb_data};
      end
   end

   //////////////////////////////////////////////////
   // Mouse

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         mouse    <= '0;
         ms_event <= 1'b0;
      end
      else
      begin
         ms_event <= ms_ready;
         if (ms_ready)
         begin
            mouse <= '{buttons: ms_button,     // Bit 2 is the head button
                       x:       ms_x,
                       y:       ms_y};
         end
      end
   end

endmodule

// File: source/iob_regs.sv
// Expects the master to hold a request until ack and wait for ack low before the next one

`timescale 1ns/1ps

module iob_regs (
   input  logic               clk,
   input  logic               reset,
   input  logic               req,
   input  iob_pkg::bus_req_t  bus,
   input  iob_pkg::key_scan_t key_scan,
   input  iob_pkg::mouse_t    mouse,
   input  logic               kb_event,
   input  logic               ms_event,
   input  iob_pkg::word_t     us_time,
   input  iob_pkg::word_t     hz60_time,
   input  logic               hz60_tick,
   output iob_pkg::word_t     dataout,
   output logic               ack,
   output logic               decode,
   output logic               hz60_start,
   output logic               interrupt,
   output logic [7:0]         vector
);

   import iob_pkg::*;

   logic [1:0] ack_q;      // Two-stage acknowledge delay
   logic       first;      // First cycle of a decoded access
   logic       rd_first;
   logic       wr_first;
   reg_off_t   off;
   word_t      rd_word;
   logic [3:0] csr;
   logic [3:0] rdy;        // 2 clock, 1 keyboard, 0 mouse
   logic [3:0] rdy_set;
   logic [3:0] rdy_clr;
   logic       kb_int;
   logic       ms_int;
   logic       clk_int;

   //////////////////////////////////////////////////
   // Decode and acknowledge

   assign decode = req && (bus.addr[21:6] == iob_base[21:6]);
   assign off    = bus.addr[5:0];
   assign ack    = ack_q[1];

   // ack_q[0] is low at the start of every request, so side
   // effects fire once however long the master holds req
   assign first    = decode && !ack_q[0];
   assign rd_first = first && !bus.write;
   assign wr_first = first && bus.write;

   always_ff @(posedge clk)
   begin
      if (reset)
         ack_q <= '0;
      else
         ack_q <= {ack_q[0], decode};
   end

   //////////////////////////////////////////////////
   // Read multiplexer

   always_comb
   begin
      case (off)
         reg_kbd_lo:  rd_word = {16'b0, key_scan[15:0]};
         reg_kbd_hi:  rd_word = {16'b0, key_scan[31:16]};
         reg_mouse_y: rd_word = {17'b0, mouse.buttons, mouse.y};
         reg_mouse_x: rd_word = {20'b0, mouse.x};      // No raw quadrature bits
         reg_beep:    rd_word = '0;
         reg_csr:     rd_word = {24'b0, rdy, csr};
         reg_us_lo:   rd_word = {16'b0, us_time[15:0]};
         reg_us_hi:   rd_word = {16'b0, us_time[31:16]};
         reg_hz60:    rd_word = hz60_time;
         default:     rd_word = '0;
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (reset)
         dataout <= '0;
      else if (decode && !bus.write)
         dataout <= rd_word;
      else
         dataout <= '0;                      // Idle and writes drive zero
   end

   //////////////////////////////////////////////////
   // Read side effects

   always_comb
   begin
      rdy_clr = '0;
      if (rd_first)
      begin
         case (off)
            reg_kbd_lo,
            reg_kbd_hi:  rdy_clr[1] = 1'b1;
            reg_mouse_y: rdy_clr[0] = 1'b1;
            reg_hz60:    rdy_clr[2] = 1'b1;
            default:     rdy_clr = '0;
         endcase
      end
   end

   assign hz60_start = rd_first && (off == reg_hz60);

   //////////////////////////////////////////////////
   // CSR and ready bits

   assign rdy_set = {1'b0, hz60_tick, kb_event, ms_event};

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         csr <= '0;
         rdy <= '0;
      end
      else
      begin
         if (wr_first && (off == reg_csr))
            csr <= bus.data[3:0];
         rdy <= (rdy & ~rdy_clr) | rdy_set;  // Set wins over read clear
      end
   end

   //////////////////////////////////////////////////
   // Interrupt and vector

   assign kb_int    = rdy[1];
   assign ms_int    = rdy[0] && csr[1];       // Mouse needs enable
   assign clk_int   = rdy[2] && csr[3];       // Clock needs enable
   assign interrupt = kb_int || ms_int || clk_int;

   always_comb
   begin
      if (kb_int || ms_int)
         vector = vec_input;
      else if (clk_int)
         vector = vec_clock;
      else
         vector = 8'h00;
   end

endmodule

// File: source/xbus_iob.sv
// Bus slave for one 64-word register block; dividers default to a 50 MHz clock

`timescale 1ns/1ps

module xbus_iob #(
   parameter int unsigned us_div   = 50,      // Cycles per microsecond
   parameter int unsigned hz60_div = 833333   // Cycles per 60 Hz tick
) (
   input  logic            clk,
   input  logic            reset,
   input  iob_pkg::addr_t  addr,
   input  iob_pkg::word_t  datain,
   input  logic            req,
   input  logic            write,
   input  logic [15:0]     kb_data,
   input  logic            kb_ready,
   input  iob_pkg::coord_t ms_x,
   input  iob_pkg::coord_t ms_y,
   input  logic [2:0]      ms_button,
   input  logic            ms_ready,
   output iob_pkg::word_t  dataout,
   output logic            ack,
   output logic            decode,
   output logic            interrupt,
   output logic [7:0]      vector
);

   import iob_pkg::*;

   bus_req_t  bus;
   key_scan_t key_scan;
   mouse_t    mouse;
   logic      kb_event;
   logic      ms_event;
   word_t     us_time;
   word_t     hz60_time;
   logic      hz60_tick;
   logic      hz60_start;

   assign bus.addr  = addr;
   assign bus.data  = datain;
   assign bus.write = write;

   //////////////////////////////////////////////////
   // Time base

   iob_timebase #(
      .us_div   (us_div),
      .hz60_div (hz60_div)
   ) u_timebase (
      .clk        (clk),
      .reset      (reset),
      .hz60_start (hz60_start),
      .us_time    (us_time),
      .hz60_time  (hz60_time),
      .hz60_tick  (hz60_tick)
   );

   //////////////////////////////////////////////////
   // Keyboard and mouse samples

   iob_input_latch u_input_latch (
      .clk       (clk),
      .reset     (reset),
      .kb_data   (kb_data),
      .kb_ready  (kb_ready),
      .ms_x      (ms_x),
      .ms_y      (ms_y),
      .ms_button (ms_button),
      .ms_ready  (ms_ready),
      .key_scan  (key_scan),
      .mouse     (mouse),
      .kb_event  (kb_event),
      .ms_event  (ms_event)
   );

   //////////////////////////////////////////////////
   // Register block

   iob_regs u_regs (
      .clk        (clk),
      .reset      (reset),
      .req        (req),
      .bus        (bus),
      .key_scan   (key_scan),
      .mouse      (mouse),
      .kb_event   (kb_event),
      .ms_event   (ms_event),
      .us_time    (us_time),
      .hz60_time  (hz60_time),
      .hz60_tick  (hz60_tick),
      .dataout    (dataout),
      .ack        (ack),
      .decode     (decode),
      .hz60_start (hz60_start),
      .interrupt  (interrupt),
      .vector     (vector)
   );

endmodule

// File: dv/xbus_iob_assert.sv
// Assumes the bus master never changes a held request before ack; checks run only outside reset

`timescale 1ns/1ps

module xbus_iob_assert (
   input logic           clk,
   input logic           reset,
   input logic           decode,
   input logic           ack,
   input logic           interrupt,
   input logic [7:0]     vector,
   input iob_pkg::word_t dataout
);

   //////////////////////////////////////////////////
   // Bus protocol

   // Two registered stages between decode and ack
   ack_after_decode: assert property (
      @(posedge clk) disable iff (reset)
      ack |-> $past(decode, 2)
   ) else $error("ack high without decode two cycles before");

   // Read data only follows a decoded cycle
   dataout_idle_zero: assert property (
      @(posedge clk) disable iff (reset)
      !$past(decode) |-> (dataout == '0)
   ) else $error("dataout nonzero after an idle cycle");

   //////////////////////////////////////////////////
   // Interrupt

   irq_vector_match: assert property (
      @(posedge clk) disable iff (reset)
      interrupt == (vector != 8'h00)
   ) else $error("interrupt and vector disagree");

endmodule

bind xbus_iob xbus_iob_assert u_xbus_iob_assert (
   .clk       (clk),
   .reset     (reset),
   .decode    (decode),
   .ack       (ack),
   .interrupt (interrupt),
   .vector    (vector),
   .dataout   (dataout)
);

// File: dv/xbus_iob_tb.sv
// Runs with small dividers (5 and 40); the clock checks allow one count of slack either way

`timescale 1ns/1ps

module xbus_iob_tb;

   import iob_pkg::*;

   localparam int max_cycles = 4000;     // Tests need about 2000

   logic       clk;
   logic       reset;
   addr_t      addr;
   word_t      datain;
   logic       req;
   logic       write;
   logic [15:0] kb_data;
   logic       kb_ready;
   coord_t     ms_x;
   coord_t     ms_y;
   logic [2:0] ms_button;
   logic       ms_ready;
   word_t      dataout;
   logic       ack;
   logic       decode;
   logic       interrupt;
   logic [7:0] vector;

   int         seed = 32'h54eb_eddd;
   int         cycles;
   int         errors;
   int         mismatches;

   // Model of the visible register state
   logic [31:0] m_scan;
   logic [2:0]  m_btn;
   coord_t      m_x;
   coord_t      m_y;
   logic [3:0]  m_csr;
   logic [3:0]  m_rdy;

   // Pending comparisons
   string       name_q[$];
   word_t       got_q[$];
   word_t       exp_q[$];

   xbus_iob #(
      .us_div   (5),
      .hz60_div (40)
   ) u_xbus_iob (
      .clk       (clk),
      .reset     (reset),
      .addr      (addr),
      .datain    (datain),
      .req       (req),
      .write     (write),
      .kb_data   (kb_data),
      .kb_ready  (kb_ready),
      .ms_x      (ms_x),
      .ms_y      (ms_y),
      .ms_button (ms_button),
      .ms_ready  (ms_ready),
      .dataout   (dataout),
      .ack       (ack),
      .decode    (decode),
      .interrupt (interrupt),
      .vector    (vector)
   );

   initial
   begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   always @(posedge clk)
   begin
      cycles <= cycles + 1;
      if (cycles >= max_cycles)
      begin
         $display("Timeout after %0d cycles, bus or interrupt never answered", cycles);
         $display("Test failed");
         $finish;
      end
   end

   //////////////////////////////////////////////////
   // Reference and comparison

   function automatic word_t ref_read(input reg_off_t off);
      case (off)
         reg_kbd_lo:  return {16'b0, m_scan[15:0]};
         reg_kbd_hi:  return {16'b0, m_scan[31:16]};
         reg_mouse_y: return {17'b0, m_btn, m_y};
         reg_mouse_x: return {20'b0, m_x};
         reg_csr:     return {24'b0, m_rdy, m_csr};
         default:     return '0;
      endcase
   endfunction

   task automatic check(input string name, input word_t got, input word_t exp);
      if (got !== exp)
      begin
         $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
         mismatches++;
      end
   endtask

   task automatic expect_val(input string name, input word_t got, input word_t exp);
      name_q.push_back(name);
      got_q.push_back(got);
      exp_q.push_back(exp);
   endtask

   always @(negedge clk)
   begin
      while (name_q.size() > 0)
         check(name_q.pop_front(), got_q.pop_front(), exp_q.pop_front());
   end

   //////////////////////////////////////////////////
   // Bus and input drivers

   task automatic bus_access(input reg_off_t off, input logic wr, input word_t d,
                             output word_t q);
      @(posedge clk);
      addr   <= {iob_base[21:6], off};
      write  <= wr;
      datain <= d;
      req    <= 1'b1;
      do @(negedge clk); while (!ack);
      q = dataout;                         // Stable while ack is high
      @(posedge clk);
      req <= 1'b0;
      do @(negedge clk); while (ack);
   endtask

   task automatic read_reg(input reg_off_t off, input string name);
      word_t exp;
      word_t q;
      exp = ref_read(off);
      bus_access(off, 1'b0, '0, q);
      expect_val(name, q, exp);
      if (off == reg_kbd_lo || off == reg_kbd_hi)
         m_rdy[1] = 1'b0;
      if (off == reg_mouse_y)
         m_rdy[0] = 1'b0;
   endtask

   task automatic write_csr(input word_t d);
      word_t q;
      bus_access(reg_csr, 1'b1, d, q);
      expect_val("dataout on write", q, '0);
      m_csr = d[3:0];
   endtask

   task automatic key_strobe(input logic [15:0] d);
      @(posedge clk);
      kb_data  <= d;
      kb_ready <= 1'b1;
      @(posedge clk);
      kb_ready <= 1'b0;
      repeat (2) @(posedge clk);
      m_scan   = {16'h00f9, d};
      m_rdy[1] = 1'b1;
   endtask

   task automatic mouse_strobe(input logic [2:0] b, input coord_t x, input coord_t y);
      @(posedge clk);
      ms_button <= b;
      ms_x      <= x;
      ms_y      <= y;
      ms_ready  <= 1'b1;
      @(posedge clk);
      ms_ready <= 1'b0;
      repeat (2) @(posedge clk);
      m_btn    = b;
      m_x      = x;
      m_y      = y;
      m_rdy[0] = 1'b1;
   endtask

   task automatic check_irq(input logic irq, input logic [7:0] vec, input string what);
      @(negedge clk);
      expect_val({what, " interrupt"}, word_t'(interrupt), word_t'(irq));
      expect_val({what, " vector"}, word_t'(vector), word_t'(vec));
   endtask

   task automatic within_one(input string what, input word_t got, input int exp);
      if (int'(got) > exp + 1 || int'(got) < exp - 1)
         check(what, got, word_t'(exp));
   endtask

   task automatic wait_irq(input int limit);
      int n;
      n = 0;
      do
      begin
         @(negedge clk);
         n++;
      end
      while (!interrupt && n < limit);
      if (!interrupt)
      begin
         $display("At %0t clock interrupt did not rise within %0d cycles", $time, limit);
         errors++;
      end
   endtask

   //////////////////////////////////////////////////
   // Test sequence

   initial
   begin
      word_t q;
      word_t t1;
      int    c0;
      int    c1;
      cycles = 0;
      errors = 0;
      mismatches = 0;
      reset = 1'b1;
      addr = '0;
      datain = '0;
      req = 1'b0;
      write = 1'b0;
      kb_data = '0;
      kb_ready = 1'b0;
      ms_x = '0;
      ms_y = '0;
      ms_button = '0;
      ms_ready = 1'b0;
      m_scan = '0;
      m_btn = '0;
      m_x = '0;
      m_y = '0;
      m_csr = '0;
      m_rdy = '0;
      repeat (10) @(posedge clk);
      reset <= 1'b0;
      repeat (2) @(posedge clk);

      // Keyboard scans and ready bit 1
      repeat (30)
      begin
         key_strobe(16'($random(seed)));
         read_reg(reg_csr, "csr after key");
         read_reg(reg_kbd_lo, "kbd_lo");
         read_reg(reg_kbd_hi, "kbd_hi");
         read_reg(reg_csr, "csr after kbd read");
      end

      // Mouse samples, empty offsets, foreign addresses
      repeat (10)
      begin
         mouse_strobe(3'($random(seed)), 12'($random(seed)), 12'($random(seed)));
         read_reg(reg_mouse_y, "mouse_y");
         read_reg(reg_mouse_x, "mouse_x");
      end
      read_reg(reg_beep, "beep");
      read_reg(6'o00, "offset 00");
      read_reg(6'o53, "offset 53");
      read_reg(6'o77, "offset 77");
      @(posedge clk);
      addr  <= {iob_base[21:6], 6'o00} + 22'o100;
      write <= 1'b0;
      req   <= 1'b1;
      repeat (6)
      begin
         @(negedge clk);
         expect_val("decode outside block", word_t'(decode), '0);
         expect_val("ack outside block", word_t'(ack), '0);
      end
      @(posedge clk);
      req <= 1'b0;

      // CSR write and readback
      repeat (8)
      begin
         write_csr(word_t'($random(seed)));
         read_reg(reg_csr, "csr readback");
      end

      // Interrupt masking and vectors
      write_csr(32'h0);
      mouse_strobe(3'b101, 12'h123, 12'h456);
      check_irq(1'b0, 8'h00, "masked mouse");
      read_reg(reg_mouse_y, "mouse_y clear");
      key_strobe(16'h1234);
      check_irq(1'b1, 8'o260, "keyboard");
      read_reg(reg_kbd_lo, "kbd_lo clear");
      check_irq(1'b0, 8'h00, "keyboard cleared");
      write_csr(32'h2);
      mouse_strobe(3'b010, 12'h0ab, 12'hcde);
      check_irq(1'b1, 8'o260, "enabled mouse");
      read_reg(reg_mouse_y, "mouse_y clear");
      check_irq(1'b0, 8'h00, "mouse cleared");

      // Microsecond clock
      bus_access(reg_us_lo, 1'b0, '0, t1);
      c0 = cycles;
      repeat (200) @(posedge clk);
      bus_access(reg_us_lo, 1'b0, '0, q);
      c1 = cycles;
      within_one("us_lo", q - t1, (c1 - c0) / 5);
      read_reg(reg_us_hi, "us_hi");

      // 60 Hz counter, started by its first read
      write_csr(32'h8);
      bus_access(reg_hz60, 1'b0, '0, q);
      c0 = cycles;
      expect_val("hz60 first read", q, '0);
      repeat (5)
      begin
         wait_irq(50);
         expect_val("clock vector", word_t'(vector), word_t'(8'o274));
         bus_access(reg_hz60, 1'b0, '0, q);
         within_one("hz60", q, (cycles - c0) / 40);
         check_irq(1'b0, 8'h00, "clock cleared");
      end

      repeat (2) @(posedge clk);
      errors = errors + mismatches;
      $display("Errors: %0d (mismatches %0d, other %0d)", errors, mismatches,
               errors - mismatches);
      if (errors == 0)
         $display("Test completed successfully");
      else
         $display("Test failed");
      $finish;
   end

endmodule

// File: xbus_iob.f
source/iob_pkg.sv
source/iob_timebase.sv
source/iob_input_latch.sv
source/iob_regs.sv
source/xbus_iob.sv
dv/xbus_iob_assert.sv
dv/xbus_iob_tb.sv
